// ==== p4_egress.f ====
verilog/egress_port_pkg.sv
verilog/egress_bus_pkg.sv
verilog/egress_demux.sv
verilog/egress_pkt_fifo.sv
verilog/egress_lane_conv.sv
verilog/egress_top.sv
bench/egress_tb.sv

// ==== Bender.yml ====
package:
  name: p4_egress

sources:
  # Design sources in compile order
  - files:
      - verilog/egress_port_pkg.sv
      - verilog/egress_bus_pkg.sv
      - verilog/egress_demux.sv
      - verilog/egress_pkt_fifo.sv
      - verilog/egress_lane_conv.sv
      - verilog/egress_top.sv

  # Testbench
  - target: test
    files:
      - bench/egress_tb.sv

// ==== bench/egress_tb.sv ====
//////////////////////////////////////////////////
// Testbench for the egress top: table-driven packets, lane monitors,
// checks of routing, partial words, overflow drop and recovery
//////////////////////////////////////////////////

`default_nettype none

module egress_tb;

    localparam logic [2:0] ph_route = 3'd0;
    localparam logic [2:0] ph_part  = 3'd1;
    localparam logic [2:0] ph_fill  = 3'd2;
    localparam logic [2:0] ph_flood = 3'd3;
    localparam logic [2:0] ph_recov = 3'd4;
    localparam int n_stim        = 20;
    localparam int flood_pkts    = 10;
    localparam int rx_timeout    = 3000;
    localparam int flood_timeout = 8000;
    localparam int idle_cycles   = 300;
    localparam int idle_timeout  = 6000;

    typedef struct packed {
        logic [2:0] phase;
        logic [1:0] port;
        logic [8:0] len;
    } stim_t;

    // One packet as rebuilt by a lane monitor
    typedef struct packed {
        logic [1:0] port;
        logic [8:0] len;
        logic [3:0] keep;
    } rx_rec_t;

    // Phase, port, byte length
    stim_t stim_tab [n_stim] = '{
        '{ph_route, 2'd0, 9'd8},   '{ph_route, 2'd1, 9'd16},  '{ph_route, 2'd2, 9'd40},
        '{ph_route, 2'd3, 9'd64},
        '{ph_part,  2'd0, 9'd65},  '{ph_part,  2'd1, 9'd70},  '{ph_part,  2'd2, 9'd65},
        '{ph_part,  2'd2, 9'd70},  '{ph_part,  2'd2, 9'd131}, '{ph_part,  2'd3, 9'd131},
        '{ph_part,  2'd3, 9'd66},  '{ph_part,  2'd1, 9'd131},
        '{ph_fill,  2'd2, 9'd37},  '{ph_fill,  2'd3, 9'd100}, '{ph_fill,  2'd0, 9'd12},
        '{ph_flood, 2'd0, 9'd256},
        '{ph_recov, 2'd0, 9'd8},   '{ph_recov, 2'd1, 9'd16},  '{ph_recov, 2'd2, 9'd40},
        '{ph_recov, 2'd3, 9'd64}
    };

    logic                                 clk_ifc;
    logic                                 arst_n;
    egress_bus_pkg::egr_word_t            in_word;
    wire egress_bus_pkg::lane_beat_t      lane_out [egress_port_pkg::num_ports];
    wire [egress_port_pkg::num_ports-1:0] overflow;

    rx_rec_t    rx_q [$];
    logic [7:0] rx_bytes [$];
    logic [7:0] tx_data [256];
    int         ovf_cnt [egress_port_pkg::num_ports];
    int         errors;
    int         timeouts;
    int         checks;

    egress_top uut (
        .clk_ifc  ( clk_ifc  ),
        .arst_n   ( arst_n   ),
        .in_word  ( in_word  ),
        .lane_out ( lane_out ),
        .overflow ( overflow )
    );

    initial begin
        clk_ifc = 1'b0;
        forever #50 clk_ifc = ~clk_ifc;
    end

    always @(posedge clk_ifc) begin
        for (int p = 0; p < egress_port_pkg::num_ports; p++) begin
            if (arst_n && overflow[p]) begin
                ovf_cnt[p]++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Lane monitors

    for (genvar p = 0; p < egress_port_pkg::num_ports; p++) begin : g_mon
        localparam int lb = egress_port_pkg::lane_bytes_of[p];
        logic [7:0] pkt [$];

        always @(posedge clk_ifc) begin
            rx_rec_t rec;
            if (arst_n && lane_out[p].valid) begin
                // Bytes above the lane width stay at zero
                if ((lane_out[p].data >> (lb * 8)) != '0) begin
                    value_error($sformatf("lane_out[%0d].data unused bytes", p),
                                lane_out[p].data >> (lb * 8), 0);
                end
                if ((lane_out[p].keep >> lb) != '0) begin
                    value_error($sformatf("lane_out[%0d].keep unused bits", p),
                                lane_out[p].keep >> lb, 0);
                end
                for (int b = 0; b < lb; b++) begin
                    if (lane_out[p].keep[b]) begin
                        pkt.push_back(lane_out[p].data[b*8 +: 8]);
                    end
                end
                if (lane_out[p].last) begin
                    rec.port = 2'(p);
                    rec.len  = 9'(pkt.size());
                    rec.keep = lane_out[p].keep;
                    rx_q.push_back(rec);
                    foreach (pkt[i]) begin
                        rx_bytes.push_back(pkt[i]);
                    end
                    pkt.delete();
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Helpers

    task automatic value_error(input string name, input int got, input int exp);
        errors++;
        $display("ERR time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
    endtask

    function automatic int ovf_total();
        int sum;
        sum = 0;
        foreach (ovf_cnt[p]) begin
            sum += ovf_cnt[p];
        end
        return sum;
    endfunction

    function automatic bit lanes_busy();
        bit busy;
        busy = 1'b0;
        for (int p = 0; p < egress_port_pkg::num_ports; p++) begin
            busy |= lane_out[p].valid;
        end
        return busy;
    endfunction

    task automatic check_quiet();
        checks++;
        for (int p = 0; p < egress_port_pkg::num_ports; p++) begin
            if (lane_out[p].valid !== 1'b0) begin
                value_error($sformatf("lane_out[%0d].valid", p), lane_out[p].valid, 0);
            end
        end
        if (overflow !== '0) begin
            value_error("overflow", overflow, 0);
        end
    endtask

    // Byte b of a packet is b mod 256, or random for filler packets
    task automatic send_pkt(input int port, input int len, input bit rnd);
        int nw;
        int w;
        int k;
        nw = (len + 7) / 8;
        for (k = 0; k < len; k++) begin
            tx_data[k] = rnd ? 8'($urandom) : 8'(k);
        end
        for (w = 0; w < nw; w++) begin
            @(posedge clk_ifc);
            in_word.valid  <= 1'b1;
            in_word.last   <= (w == nw - 1);
            in_word.nbytes <= (w == nw - 1) ? 4'(len - 8 * w) : 4'd8;
            in_word.port   <= 2'(port);
            for (k = 0; k < 8; k++) begin
                in_word.data[k*8 +: 8] <= (8 * w + k < len) ? tx_data[8 * w + k] : 8'h00;
            end
        end
    endtask

    task automatic end_input();
        @(posedge clk_ifc);
        in_word <= '0;
    endtask

    task automatic wait_rx(input int n);
        int t;
        t = 0;
        while (rx_q.size() < n && t < rx_timeout) begin
            @(negedge clk_ifc);
            t++;
        end
        if (rx_q.size() < n) begin
            errors++;
            timeouts++;
            $display("Timeout: no packet came out on any lane within %0d cycles", rx_timeout);
        end
    endtask

    task automatic wait_idle(input int cycles);
        int quiet;
        int t;
        quiet = 0;
        t = 0;
        while (quiet < cycles && t < idle_timeout) begin
            @(negedge clk_ifc);
            quiet = lanes_busy() ? 0 : quiet + 1;
            t++;
        end
        if (quiet < cycles) begin
            errors++;
            timeouts++;
            $display("Timeout: lanes never stayed idle for %0d cycles", cycles);
        end
    endtask

    // Pops one received packet and compares it with the last one sent
    task automatic check_pkt(input int port, input int len);
        rx_rec_t    rec;
        int         lb;
        int         rem;
        int         b;
        logic [3:0] exp_keep;
        logic [7:0] got;
        bit         bad;
        rec = rx_q.pop_front();
        lb = egress_port_pkg::lane_bytes_of[port];
        rem = len % lb;
        exp_keep = 4'((1 << (rem == 0 ? lb : rem)) - 1);
        bad = 1'b0;
        checks++;
        if (rec.port != port) begin
            value_error("lane_out port", rec.port, port);
        end
        if (rec.len != len) begin
            value_error($sformatf("lane_out[%0d] byte count", rec.port), rec.len, len);
        end
        if (rec.keep != exp_keep) begin
            value_error($sformatf("lane_out[%0d].keep last", rec.port), rec.keep, exp_keep);
        end
        for (b = 0; b < rec.len; b++) begin
            got = rx_bytes.pop_front();
            if (!bad && b < len && got != tx_data[b]) begin
                bad = 1'b1;
                value_error($sformatf("lane_out[%0d].data byte %0d", rec.port, b),
                            got, tx_data[b]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Phases

    task automatic run_single(input stim_t s);
        int ovf_before;
        ovf_before = ovf_total();
        send_pkt(s.port, s.len, s.phase == ph_fill);
        end_input();
        wait_rx(1);
        if (rx_q.size() > 0) begin
            check_pkt(s.port, s.len);
        end
        // A copy on a lane of another width may still be in flight
        wait_idle(2);
        checks++;
        if (rx_q.size() != 0) begin
            errors++;
            $display("Packet for port %0d came out on more than one lane", s.port);
            rx_q.delete();
            rx_bytes.delete();
        end
        checks++;
        if (ovf_total() != ovf_before) begin
            errors++;
            $display("Overflow raised while a single packet went to port %0d", s.port);
        end
    endtask

    // Back to back packets to one narrow port, each is either received or dropped
    task automatic run_flood(input stim_t s);
        int ovf_before;
        int pulses;
        int got;
        int t;
        int i;
        ovf_before = ovf_cnt[s.port];
        for (i = 0; i < flood_pkts; i++) begin
            send_pkt(s.port, s.len, 1'b0);
        end
        end_input();
        t = 0;
        pulses = ovf_cnt[s.port] - ovf_before;
        while (rx_q.size() + pulses < flood_pkts && t < flood_timeout) begin
            @(negedge clk_ifc);
            pulses = ovf_cnt[s.port] - ovf_before;
            t++;
        end
        if (rx_q.size() + pulses < flood_pkts) begin
            errors++;
            timeouts++;
            $display("Timeout: flood packets on port %0d were neither received nor dropped",
                     s.port);
        end
        // Any surplus packet still on a lane must finish before counting
        wait_idle(2);
        pulses = ovf_cnt[s.port] - ovf_before;
        got = rx_q.size();
        checks++;
        if (got + pulses != flood_pkts) begin
            value_error("received plus overflow count", got + pulses, flood_pkts);
        end
        checks++;
        if (pulses == 0) begin
            errors++;
            $display("No overflow pulse on port %0d during the flood", s.port);
        end
        for (i = 0; i < got; i++) begin
            check_pkt(s.port, s.len);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        int i;
        bit idle_done;
        in_word = '0;
        arst_n = 1'b0;
        errors = 0;
        timeouts = 0;
        checks = 0;
        idle_done = 1'b0;
        foreach (ovf_cnt[p]) begin
            ovf_cnt[p] = 0;
        end
        void'($urandom(34762));

        for (i = 0; i < 8; i++) begin
            @(negedge clk_ifc);
            check_quiet();
        end
        @(posedge clk_ifc);
        arst_n <= 1'b1;
        for (i = 0; i < 4; i++) begin
            @(negedge clk_ifc);
            check_quiet();
        end

        for (i = 0; i < n_stim; i++) begin
            // Recovery starts from a fully drained router
            if (stim_tab[i].phase == ph_recov && !idle_done) begin
                wait_idle(idle_cycles);
                idle_done = 1'b1;
            end
            if (stim_tab[i].phase == ph_flood) begin
                run_flood(stim_tab[i]);
            end else begin
                run_single(stim_tab[i]);
            end
        end

        $display("checks=%0d errors=%0d timeouts=%0d overflow pulses=%0d",
                 checks, errors, timeouts, ovf_total());
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/egress_top.sv ====
//////////////////////////////////////////////////
// Egress top: demux into four packet buffers, each feeding its lane
//////////////////////////////////////////////////

`default_nettype none

module egress_top (
    input  wire                                  clk_ifc,
    input  wire                                  arst_n,
    input  wire egress_bus_pkg::egr_word_t       in_word,
    output wire egress_bus_pkg::lane_beat_t      lane_out [egress_port_pkg::num_ports],
    output wire [egress_port_pkg::num_ports-1:0] overflow
);

    egress_bus_pkg::buf_word_t             wr_word [egress_port_pkg::num_ports];
    logic [egress_port_pkg::num_ports-1:0] wr_en;
    wire egress_bus_pkg::buf_word_t        rd_word [egress_port_pkg::num_ports];
    wire [egress_port_pkg::num_ports-1:0]  avail;
    wire [egress_port_pkg::num_ports-1:0]  rd_en;

    egress_demux demux (
        .clk_ifc ( clk_ifc ),
        .arst_n  ( arst_n  ),
        .in_word ( in_word ),
        .wr_word ( wr_word ),
        .wr_en   ( wr_en   )
    );

    //////////////////////////////////////////////////
    // One buffer and converter per port

    for (genvar p = 0; p < egress_port_pkg::num_ports; p++) begin : g_port

        egress_pkt_fifo fifo (
            .clk_ifc  ( clk_ifc     ),
            .arst_n   ( arst_n      ),
            .wr_word  ( wr_word[p]  ),
            .wr_en    ( wr_en[p]    ),
            .rd_en    ( rd_en[p]    ),
            .rd_word  ( rd_word[p]  ),
            .avail    ( avail[p]    ),
            .overflow ( overflow[p] )
        );

        // Lane width comes from the port table
        egress_lane_conv #(
            .lane_bytes ( egress_port_pkg::lane_bytes_of[p] )
        ) conv (
            .clk_ifc ( clk_ifc     ),
            .arst_n  ( arst_n      ),
            .rd_word ( rd_word[p]  ),
            .avail   ( avail[p]    ),
            .rd_en   ( rd_en[p]    ),
            .lane    ( lane_out[p] )
        );

    end

endmodule

`default_nettype wire

// ==== verilog/egress_lane_conv.sv ====
//////////////////////////////////////////////////
// Serializes buffered 64-bit words onto one lane of lane_bytes bytes
//////////////////////////////////////////////////

`default_nettype none

module egress_lane_conv #(
    // Bytes per lane beat, 1, 2 or 4
    parameter int lane_bytes = 4
) (
    input  wire                              clk_ifc,
    input  wire                              arst_n,
    input  wire egress_bus_pkg::buf_word_t   rd_word,
    input  wire                              avail,
    output logic                             rd_en,
    output egress_bus_pkg::lane_beat_t       lane
);

    localparam int lane_bits = lane_bytes * 8;
    localparam int cnt_bits = egress_bus_pkg::byte_cnt_bits;
    localparam logic [cnt_bits-1:0] lane_cnt = cnt_bits'(lane_bytes);

    logic [egress_bus_pkg::word_bits-1:0] sh_data;
    logic                                 sh_last;
    // Bytes of the current word not yet sent, zero when idle
    logic [cnt_bits-1:0]                  rem;

    // Pop when idle or on the final beat of a word
    // A whole packet is committed, so avail stays high inside it
    assign rd_en = avail && (rem <= lane_cnt);

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            rem <= '0;
        end else if (rd_en) begin
            rem <= rd_word.last ? rd_word.nbytes : cnt_bits'(egress_bus_pkg::word_bytes);
        end else if (rem > lane_cnt) begin
            rem <= rem - lane_cnt;
        end else begin
            rem <= '0;
        end
    end

    // Low bytes always hold the beat being sent
    always_ff @(posedge clk_ifc) begin
        if (rd_en) begin
            sh_data <= rd_word.data;
            sh_last <= rd_word.last;
        end else begin
            sh_data <= sh_data >> lane_bits;
        end
    end

    //////////////////////////////////////////////////
    // Lane beat

    always_comb begin
        lane       = '0;
        lane.valid = rem != '0;
        // Final beat of the last word closes the packet
        lane.last  = sh_last && rem != '0 && rem <= lane_cnt;
        for (int b = 0; b < lane_bytes; b++) begin
            lane.keep[b]        = rem > cnt_bits'(b);
            lane.data[b*8 +: 8] = sh_data[b*8 +: 8];
        end
    end

    // A last word carries 1 to word_bytes bytes, so its closing beat has keep set
    a_last_has_keep : assert property (@(posedge clk_ifc) disable iff (!arst_n)
        rd_en && rd_word.last |-> rd_word.nbytes != '0 &&
            rd_word.nbytes <= cnt_bits'(egress_bus_pkg::word_bytes));

endmodule

`default_nettype wire

// ==== verilog/egress_pkt_fifo.sv ====
//////////////////////////////////////////////////
// Store-and-forward packet buffer for one egress port
// Drops a whole packet when it finds no room and flags overflow
//////////////////////////////////////////////////

`default_nettype none

module egress_pkt_fifo (
    input  wire                              clk_ifc,
    input  wire                              arst_n,
    input  wire egress_bus_pkg::buf_word_t   wr_word,
    input  wire                              wr_en,
    input  wire                              rd_en,
    output egress_bus_pkg::buf_word_t        rd_word,
    output logic                             avail,
    output logic                             overflow
);

    // Extra pointer bit tells a full buffer from an empty one
    localparam int ptr_bits = egress_port_pkg::fifo_addr_bits + 1;
    localparam int max_pkt_words = egress_port_pkg::max_pkt_bytes / egress_bus_pkg::word_bytes;

    egress_bus_pkg::buf_word_t mem [egress_port_pkg::fifo_depth];

    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] commit_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] fill;
    logic                full;
    logic                dropping;
    logic                accept;

    assign fill   = wr_ptr - rd_ptr;
    assign full   = fill == ptr_bits'(egress_port_pkg::fifo_depth);
    assign accept = wr_en && !dropping && !full;

    // Only committed packets are visible to the reader
    assign avail   = rd_ptr != commit_ptr;
    assign rd_word = mem[rd_ptr[egress_port_pkg::fifo_addr_bits-1:0]];

    //////////////////////////////////////////////////
    // Write side

    always_ff @(posedge clk_ifc) begin
        if (accept) begin
            mem[wr_ptr[egress_port_pkg::fifo_addr_bits-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            dropping   <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (wr_en) begin
                if (dropping) begin
                    // Discard up to and including the last word
                    dropping <= !wr_word.last;
                end else if (full) begin
                    // Rewind over the partial packet and flag it once
                    overflow <= 1'b1;
                    wr_ptr   <= commit_ptr;
                    dropping <= !wr_word.last;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr_word.last) begin
                        commit_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Read side

    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    // Converter must only pop committed words
    a_no_underrun : assert property (@(posedge clk_ifc) disable iff (!arst_n)
        rd_en |-> avail);

    // Overflow is 1 cycle behind its write, so the packet end is taken from $past
    a_one_ovf_per_pkt : assert property (@(posedge clk_ifc) disable iff (!arst_n)
        (wr_en && !wr_word.last) ##1 overflow
        |=> !overflow until_with $past(wr_en && wr_word.last));

    // An open packet never grows past the largest legal size
    a_pkt_size : assert property (@(posedge clk_ifc) disable iff (!arst_n)
        accept |-> wr_ptr - commit_ptr < ptr_bits'(max_pkt_words));

endmodule

`default_nettype wire

// ==== verilog/egress_demux.sv ====
//////////////////////////////////////////////////
// Registers the input word and steers it to the buffer of its port
//////////////////////////////////////////////////

`default_nettype none

module egress_demux (
    input  wire                                   clk_ifc,
    input  wire                                   arst_n,
    input  wire egress_bus_pkg::egr_word_t        in_word,
    output egress_bus_pkg::buf_word_t             wr_word [egress_port_pkg::num_ports],
    output logic [egress_port_pkg::num_ports-1:0] wr_en
);

    egress_bus_pkg::buf_word_t             word_q;
    logic [egress_port_pkg::port_bits-1:0] port_q;
    logic                                  mid_pkt;

    // One-hot write strobe, one cycle after the input word
    always_ff @(posedge clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            wr_en   <= '0;
            mid_pkt <= 1'b0;
        end else begin
            wr_en <= '0;
            if (in_word.valid) begin
                wr_en[in_word.port] <= 1'b1;
                mid_pkt             <= !in_word.last;
            end
        end
    end

    // Word payload with the port field stripped
    always_ff @(posedge clk_ifc) begin
        if (in_word.valid) begin
            word_q.data   <= in_word.data;
            word_q.last   <= in_word.last;
            word_q.nbytes <= in_word.nbytes;
            port_q        <= in_word.port;
        end
    end

    // Every buffer sees the same word, only its strobe differs
    always_comb begin
        for (int p = 0; p < egress_port_pkg::num_ports; p++) begin
            wr_word[p] = word_q;
        end
    end

    // All words of a packet go to one port
    a_port_stable : assert property (@(posedge clk_ifc) disable iff (!arst_n)
        in_word.valid && mid_pkt |-> in_word.port == port_q);

endmodule

`default_nettype wire

// ==== verilog/egress_bus_pkg.sv ====
//////////////////////////////////////////////////
// Word, stored-word and lane-beat types of the egress datapath
// Referenced by scoped names from the demux, buffers and converters
//////////////////////////////////////////////////

`default_nettype none

package egress_bus_pkg;

    //////////////////////////////////////////////////
    // Bus widths

    // Bytes carried by one input word
    localparam int word_bytes = 8;
    localparam int word_bits = word_bytes * 8;

    // Holds a valid-byte count from 0 to word_bytes
    localparam int byte_cnt_bits = 4;

    // Widest physical lane, sets the keep and data width of a beat
    localparam int lane_max_bytes = 4;

    //////////////////////////////////////////////////
    // Word types

    // Input word from the router, port selects the egress buffer
    typedef struct packed {
        logic                                  valid;
        logic                                  last;
        logic [byte_cnt_bits-1:0]              nbytes;
        logic [egress_port_pkg::port_bits-1:0] port;
        logic [word_bits-1:0]                  data;
    } egr_word_t;

    // Word as held in a port buffer, nbytes only counts on the last word
    typedef struct packed {
        logic [word_bits-1:0]     data;
        logic                     last;
        logic [byte_cnt_bits-1:0] nbytes;
    } buf_word_t;

    // One beat on a physical lane; narrow lanes use the low bytes only
    typedef struct packed {
        logic                        valid;
        logic                        last;
        logic [lane_max_bytes-1:0]   keep;
        logic [lane_max_bytes*8-1:0] data;
    } lane_beat_t;

endpackage

`default_nettype wire

// ==== verilog/egress_port_pkg.sv ====
//////////////////////////////////////////////////
// Port count, lane width per port and buffer sizing
//////////////////////////////////////////////////

`default_nettype none

package egress_port_pkg;

    //////////////////////////////////////////////////
    // Port map

    localparam int num_ports = 4;
    localparam int port_bits = 2;

    // Lane width in bytes for each port
    // Ports 0 and 1 are byte lanes, ports 2 and 3 are 32-bit lanes
    localparam int lane_bytes_of [num_ports] = '{1, 1, 4, 4};

    //////////////////////////////////////////////////
    // Buffer sizing

    // 64 words of 8 bytes, room for two of the largest packets
    localparam int fifo_depth = 64;
    localparam int fifo_addr_bits = 6;

    // Largest packet the router sends
    localparam int max_pkt_bytes = 256;

endpackage

`default_nettype wire
